// ==== Makefile ====
# Verilator flow for the UART with APB registers
# any variable can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= uart_tb
FLIST     ?= uart_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the log decides the result, a missing pass line counts as a failure too
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/uart_apb_regs.sv ====
module uart_apb_regs (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::apb_req_t   apb_req,
   output uart_pkg::apb_rsp_t   apb_rsp,
   output uart_pkg::uart_char_t tx_data,
   output logic                 tx_start,
   input  logic                 tx_busy,
   input  uart_pkg::uart_char_t rx_data,
   input  logic                 rx_valid
);
   import uart_pkg::*;

   logic       access;
   logic       sel_data;
   logic       sel_ctrl;
   logic       mapped;
   logic       tx_wait;
   logic       done;
   logic       rd_data_done;
   logic       ovr_clear;
   uart_char_t rx_char_q;
   logic       rx_full_q;
   logic       overrun_q;
   apb_data_t  data_word;
   apb_data_t  ctrl_word;

   // -------------------------------------------------------------------
   // transfer decode
   // -------------------------------------------------------------------

   // second and later cycles of a transfer
   assign access   = apb_req.psel && apb_req.penable;
   assign sel_data = (apb_req.paddr == uart_data_addr);
   assign sel_ctrl = (apb_req.paddr == uart_ctrl_addr);
   assign mapped   = sel_data || sel_ctrl;

   // a character write has to wait for the transmitter to go idle
   assign tx_wait = access && apb_req.pwrite && sel_data && tx_busy;

   // the access cycle in which the transfer completes
   assign done = access && !tx_wait;

   assign rd_data_done = done && !apb_req.pwrite && sel_data;
   assign ovr_clear    = done && apb_req.pwrite && sel_ctrl && apb_req.pwdata[overrun_bit];

   // the transmitter latches the byte in the same cycle as the start pulse
   assign tx_data  = apb_req.pwdata[7:0];
   assign tx_start = done && apb_req.pwrite && sel_data;

   // -------------------------------------------------------------------
   // one-character receive buffer and flags
   // -------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         rx_char_q <= rx_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_full_q <= 1'b0;
         overrun_q <= 1'b0;
      end else begin
         // a new character beats a read that empties the buffer in the same cycle
         if (rx_valid) begin
            rx_full_q <= 1'b1;
         end else if (rd_data_done) begin
            rx_full_q <= 1'b0;
         end
         // overrun only when the old character is lost unread
         if (rx_valid && rx_full_q && !rd_data_done) begin
            overrun_q <= 1'b1;
         end else if (ovr_clear) begin
            overrun_q <= 1'b0;
         end
      end
   end

   // -------------------------------------------------------------------
   // read words and response
   // -------------------------------------------------------------------

   always_comb begin
      data_word = '0;
      data_word[7:0] = rx_char_q;
      data_word[rx_valid_bit] = rx_full_q;
      // available count is 0 or 1, so only the field lsb can be set
      data_word[space_lsb] = rx_full_q;

      ctrl_word = '0;
      // one slot of transmit space while the transmitter is idle
      ctrl_word[space_lsb] = !tx_busy;
      ctrl_word[overrun_bit] = overrun_q;
   end

   always_comb begin
      apb_rsp = '0;
      apb_rsp.pready = !tx_wait;
      // unmapped offsets complete at once but report an error
      apb_rsp.pslverr = done && !mapped;
      if (access && !apb_req.pwrite) begin
         if (sel_data) begin
            apb_rsp.prdata = data_word;
         end else if (sel_ctrl) begin
            apb_rsp.prdata = ctrl_word;
         end
      end
   end

endmodule

// ==== source/uart_pkg.sv ====
package uart_pkg;

   // -------------------------------------------------------------------
   // vector types with a meaning of their own
   // -------------------------------------------------------------------

   // one character on the serial line
   typedef logic [7:0]  uart_char_t;
   // byte address on the APB side, only the low nibble is decoded
   typedef logic [3:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;
   // index of a data bit within a frame
   typedef logic [3:0]  bit_count_t;

   // -------------------------------------------------------------------
   // register map
   // -------------------------------------------------------------------

   localparam apb_addr_t uart_data_addr = 4'h0;
   localparam apb_addr_t uart_ctrl_addr = 4'h4;

   // receive-valid flag in the data register
   localparam int unsigned rx_valid_bit = 15;
   // sticky overrun flag in the control register, write 1 to clear
   localparam int unsigned overrun_bit  = 10;
   // lsb of the upper half-word count fields (rx available and tx space)
   localparam int unsigned space_lsb    = 16;

   // index of the last of the eight data bits
   localparam bit_count_t data_bits_last = 4'd7;

   // -------------------------------------------------------------------
   // APB request and response bundles
   // -------------------------------------------------------------------

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // serial state machines, prefixed so both can be imported together
   typedef enum logic [1:0] {tx_st_idle, tx_st_start, tx_st_data, tx_st_stop} tx_state_t;
   typedef enum logic [1:0] {rx_st_idle, rx_st_start, rx_st_data, rx_st_stop} rx_state_t;

endpackage

// ==== source/uart_rx.sv ====
module uart_rx #(
   parameter int unsigned cycles_per_bit = 16
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 serial_in,
   output uart_pkg::uart_char_t rx_data,
   output logic                 rx_valid
);
   import uart_pkg::*;

   localparam int unsigned      cnt_w     = $clog2(cycles_per_bit);
   localparam logic [cnt_w-1:0] bit_last  = cnt_w'(cycles_per_bit - 1);
   localparam logic [cnt_w-1:0] half_last = cnt_w'(cycles_per_bit / 2 - 1);

   logic [1:0]       sync_q;
   logic             line;
   logic             line_prev_q;
   rx_state_t        state_q;
   logic [cnt_w-1:0] cnt_q;
   bit_count_t       bit_idx_q;
   uart_char_t       shift_q;
   logic             bit_end;
   logic             frame_ok;

   // -------------------------------------------------------------------
   // line synchronizer and edge history
   // -------------------------------------------------------------------

   // the idle line is high, so the flops come out of reset that way
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q      <= 2'b11;
         line_prev_q <= 1'b1;
      end else begin
         sync_q      <= {sync_q[0], serial_in};
         line_prev_q <= line;
      end
   end

   assign line = sync_q[1];

   // middle of a data or stop bit
   assign bit_end = (cnt_q == bit_last);

   // stop bit sampled high at its centre completes the frame
   assign frame_ok = (state_q == rx_st_stop) && bit_end && line;

   // data bits arrive lsb first, so they enter from the top
   always_ff @(posedge clk) begin
      if (state_q == rx_st_data && bit_end) begin
         shift_q <= {line, shift_q[7:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (frame_ok) begin
         rx_data <= shift_q;
      end
   end

   // -------------------------------------------------------------------
   // frame sequencer
   // -------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= rx_st_idle;
         cnt_q     <= '0;
         bit_idx_q <= '0;
         rx_valid  <= 1'b0;
      end else begin
         rx_valid <= frame_ok;
         case (state_q)
            rx_st_idle: begin
               cnt_q <= '0;
               // a real falling edge is needed, a line stuck low does not start a frame
               if (line_prev_q && !line) begin
                  state_q <= rx_st_start;
               end
            end
            rx_st_start: begin
               if (cnt_q == half_last) begin
                  cnt_q     <= '0;
                  bit_idx_q <= '0;
                  // still low at mid-bit, otherwise it was a glitch
                  state_q   <= line ? rx_st_idle : rx_st_data;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            rx_st_data: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  if (bit_idx_q == data_bits_last) begin
                     state_q <= rx_st_stop;
                  end else begin
                     bit_idx_q <= bit_idx_q + 1'b1;
                  end
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            rx_st_stop: begin
               // back to idle at mid stop bit, a low stop bit drops the frame
               if (bit_end) begin
                  cnt_q   <= '0;
                  state_q <= rx_st_idle;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               state_q <= rx_st_idle;
            end
         endcase
      end
   end

endmodule

// ==== source/uart_top.sv ====
module uart_top #(
   parameter int unsigned clk_freq_hz = 25_000_000,
   parameter int unsigned baud_rate   = 1_562_500
) (
   input  logic               clk,
   input  logic               rst_n,
   input  uart_pkg::apb_req_t apb_req,
   output uart_pkg::apb_rsp_t apb_rsp,
   input  logic               serial_in,
   output logic               serial_out
);
   import uart_pkg::*;

   // bit period in clocks, rounded to the nearest whole cycle
   localparam int unsigned cycles_per_bit = (clk_freq_hz + baud_rate / 2) / baud_rate;

   uart_char_t tx_data;
   logic       tx_start;
   logic       tx_busy;
   uart_char_t rx_data;
   logic       rx_valid;

   // -------------------------------------------------------------------
   // register block between APB and the two serial engines
   // -------------------------------------------------------------------

   uart_apb_regs u_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .tx_data  (tx_data),
      .tx_start (tx_start),
      .tx_busy  (tx_busy),
      .rx_data  (rx_data),
      .rx_valid (rx_valid)
   );

   uart_tx #(.cycles_per_bit(cycles_per_bit)) u_tx (
      .clk        (clk),
      .rst_n      (rst_n),
      .tx_data    (tx_data),
      .tx_start   (tx_start),
      .tx_busy    (tx_busy),
      .serial_out (serial_out)
   );

   uart_rx #(.cycles_per_bit(cycles_per_bit)) u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .serial_in (serial_in),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

endmodule

// ==== source/uart_tx.sv ====
module uart_tx #(
   parameter int unsigned cycles_per_bit = 16
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::uart_char_t tx_data,
   input  logic                 tx_start,
   output logic                 tx_busy,
   output logic                 serial_out
);
   import uart_pkg::*;

   localparam int unsigned      cnt_w    = $clog2(cycles_per_bit);
   localparam logic [cnt_w-1:0] bit_last = cnt_w'(cycles_per_bit - 1);

   tx_state_t        state_q;
   logic [cnt_w-1:0] cnt_q;
   bit_count_t       bit_idx_q;
   uart_char_t       shift_q;
   logic             bit_end;

   // the current bit has been on the line for a full bit period
   assign bit_end = (cnt_q == bit_last);

   // busy covers the start bit, the data bits and the stop bit
   assign tx_busy = (state_q != tx_st_idle);

   // character is taken on the start pulse, then shifted right after each data bit
   always_ff @(posedge clk) begin
      if (state_q == tx_st_idle && tx_start) begin
         shift_q <= tx_data;
      end else if (state_q == tx_st_data && bit_end) begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   // -------------------------------------------------------------------
   // frame sequencer
   // -------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= tx_st_idle;
         cnt_q      <= '0;
         bit_idx_q  <= '0;
         serial_out <= 1'b1;
      end else begin
         case (state_q)
            tx_st_idle: begin
               cnt_q <= '0;
               // line drops to the start bit on the clock after the pulse
               if (tx_start) begin
                  state_q    <= tx_st_start;
                  serial_out <= 1'b0;
               end
            end
            tx_st_start: begin
               if (bit_end) begin
                  cnt_q      <= '0;
                  bit_idx_q  <= '0;
                  state_q    <= tx_st_data;
                  // lsb goes first
                  serial_out <= shift_q[0];
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            tx_st_data: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  if (bit_idx_q == data_bits_last) begin
                     state_q    <= tx_st_stop;
                     serial_out <= 1'b1;
                  end else begin
                     bit_idx_q  <= bit_idx_q + 1'b1;
                     // the next bit sits one place up until the shift lands
                     serial_out <= shift_q[1];
                  end
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            tx_st_stop: begin
               // line is already high, only the stop period has to run out
               if (bit_end) begin
                  cnt_q   <= '0;
                  state_q <= tx_st_idle;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               state_q    <= tx_st_idle;
               serial_out <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== uart_top.f ====
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_apb_regs.sv
source/uart_top.sv
verif/uart_checker.sv
verif/uart_tb.sv

// ==== verif/uart_checker.sv ====
module uart_checker (
   input logic               clk,
   input logic               rst_n,
   input uart_pkg::apb_req_t apb_req,
   input uart_pkg::apb_rsp_t apb_rsp,
   input logic               tx_busy,
   input logic               serial_out
);
   timeunit 1ns;
   timeprecision 100ps;

   // count of assertion failures in this run
   int assert_errors = 0;

   // ---------------------------------------------------------------------
   // serial line rules
   // ---------------------------------------------------------------------

   // the line rests high whenever the control register reports transmit space
   line_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
      !tx_busy |-> serial_out)
      else begin
         $error("serial_out low while no frame is being sent");
         assert_errors++;
      end

   // ---------------------------------------------------------------------
   // APB rules
   // ---------------------------------------------------------------------

   // an error response only shows up in the access cycle that ends the transfer
   slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
      apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable && apb_rsp.pready))
      else begin
         $error("pslverr high outside a finishing access cycle");
         assert_errors++;
      end

   // a stalled access keeps address, direction and data unchanged
   req_stable_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
      (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
      else begin
         $error("APB request changed while pready was low");
         assert_errors++;
      end

endmodule

bind uart_top uart_checker u_checker (
   .clk        (clk),
   .rst_n      (rst_n),
   .apb_req    (apb_req),
   .apb_rsp    (apb_rsp),
   .tx_busy    (tx_busy),
   .serial_out (serial_out)
);

// ==== verif/uart_tb.sv ====
module uart_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import uart_pkg::*;

   localparam int        clk_freq_hz = 25_000_000;
   localparam int        baud_rate   = 1_562_500;
   localparam int        bit_cycles  = clk_freq_hz / baud_rate;
   localparam int        bit_ns      = bit_cycles * 40;
   localparam int        n_chars     = 8;
   localparam int        n_tests     = 6;
   // every character of every test gets 12 bit times, plus some slack for reset
   localparam int        watchdog_ns = n_chars * 12 * bit_ns * n_tests + 20_000;
   localparam int        max_polls   = 200;
   localparam apb_addr_t bad_addr    = 4'h8;

   logic        clk = 1'b0;
   logic        rst_n;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic        serial_in;
   logic        serial_out;
   logic        bang_en;
   logic        bang_line;
   logic [31:0] lcg_state;
   int          errors = 0;
   int          misc_errors = 0;
   int          failed_tests = 0;
   int          pushed = 0;
   int          checked = 0;
   string       name_q[$];
   apb_data_t   got_q[$];
   apb_data_t   exp_q[$];
   apb_data_t   mask_q[$];

   always #20 clk = ~clk;

   // loopback unless the bit-banging task owns the line
   assign serial_in = bang_en ? bang_line : serial_out;

   uart_top #(.clk_freq_hz(clk_freq_hz), .baud_rate(baud_rate)) uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .serial_in  (serial_in),
      .serial_out (serial_out)
   );

   // ---------------------------------------------------------------------
   // reference model and stimulus helpers
   // ---------------------------------------------------------------------

   // expected register word from the modelled character, flags and busy state
   function automatic apb_data_t ref_word(input apb_addr_t addr, input uart_char_t ch,
                                          input logic valid, input logic ovr, input logic busy);
      apb_data_t w;
      w = '0;
      if (addr == uart_data_addr) begin
         w[7:0] = ch;
         w[rx_valid_bit] = valid;
         // one-deep buffer, so the available count is the valid flag
         w[space_lsb +: 16] = valid ? 16'd1 : 16'd0;
      end else if (addr == uart_ctrl_addr) begin
         w[space_lsb +: 16] = busy ? 16'd0 : 16'd1;
         w[overrun_bit] = ovr;
      end
      return w;
   endfunction

   // the character byte means nothing while the valid flag is clear
   function automatic apb_data_t data_mask(input logic valid);
      return valid ? 32'hffff_ffff : 32'hffff_ff00;
   endfunction

   function automatic uart_char_t next_char();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   function automatic int total_errors();
      return errors + misc_errors + uut.u_checker.assert_errors;
   endfunction

   // one APB transfer, driven on falling edges and sampled on rising edges
   task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err, output int waits);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clk);
      apb_req.penable = 1'b1;
      waits = 0;
      @(posedge clk);
      while (apb_rsp.pready !== 1'b1) begin
         waits++;
         @(posedge clk);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                            output int waits, output logic err);
      apb_data_t unused;
      apb_xfer(1'b1, addr, data, unused, err, waits);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      int waits;
      apb_xfer(1'b0, addr, '0, data, err, waits);
   endtask

   // hand a result to the compare process
   task automatic expect_word(input string name, input apb_data_t got,
                              input apb_data_t exp, input apb_data_t mask);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
      mask_q.push_back(mask);
      pushed++;
   endtask

   task automatic read_expect(input apb_addr_t addr, input string name,
                              input apb_data_t exp, input apb_data_t mask);
      apb_data_t word;
      logic      err;
      apb_read(addr, word, err);
      expect_word(name, word, exp, mask);
   endtask

   // poll the data register until a character is there, that read empties it
   task automatic receive_char(input uart_char_t ch, input string name);
      apb_data_t word;
      logic      err;
      int        polls;
      polls = 0;
      word  = '0;
      while (word[rx_valid_bit] !== 1'b1 && polls < max_polls) begin
         apb_read(uart_data_addr, word, err);
         polls++;
      end
      if (word[rx_valid_bit] === 1'b1) begin
         expect_word(name, word, ref_word(uart_data_addr, ch, 1'b1, 1'b0, 1'b0), '1);
      end else begin
         $display("no character arrived in the data register after %0d polls", polls);
         misc_errors++;
      end
   endtask

   // poll the control register until the transmitter reports space again
   task automatic wait_tx_idle();
      apb_data_t word;
      logic      err;
      int        polls;
      polls = 0;
      word  = '0;
      while (word[space_lsb] !== 1'b1 && polls < max_polls) begin
         apb_read(uart_ctrl_addr, word, err);
         polls++;
      end
      if (word[space_lsb] !== 1'b1) begin
         $display("the transmitter stayed busy for %0d polls of the control register", polls);
         misc_errors++;
      end
   endtask

   // start bit, eight data bits lsb first, chosen stop bit, then two idle bits
   task automatic bang_frame(input uart_char_t ch, input logic stop_bit);
      logic [9:0] frame;
      int         i;
      frame = {stop_bit, ch, 1'b0};
      @(negedge clk);
      bang_en = 1'b1;
      for (i = 0; i < 10; i++) begin
         bang_line = frame[i];
         repeat (bit_cycles) @(negedge clk);
      end
      bang_line = 1'b1;
      repeat (2 * bit_cycles) @(negedge clk);
      bang_en = 1'b0;
   endtask

   task automatic finish_test(input int num, input string name, input int base);
      int errs;
      wait (pushed == checked);
      errs = total_errors() - base;
      if (errs == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errs);
         failed_tests++;
      end
   endtask

   // ---------------------------------------------------------------------
   // compare process and watchdog
   // ---------------------------------------------------------------------

   initial begin
      string     name;
      apb_data_t got;
      apb_data_t exp;
      apb_data_t mask;
      forever begin
         wait (pushed != checked);
         name = name_q.pop_front();
         got  = got_q.pop_front();
         exp  = exp_q.pop_front();
         mask = mask_q.pop_front();
         if ((got & mask) !== (exp & mask)) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
         end
         checked++;
      end
   end

   initial begin
      #(watchdog_ns);
      $display("timeout, the tests did not finish within %0d ns", watchdog_ns);
      $display("Test failed");
      $finish;
   end

   // ---------------------------------------------------------------------
   // test sequence
   // ---------------------------------------------------------------------

   initial begin
      uart_char_t ch;
      uart_char_t prev;
      apb_data_t  word;
      int         waits;
      logic       err;
      int         base;
      int         i;

      apb_req   = '0;
      bang_en   = 1'b0;
      bang_line = 1'b1;
      rst_n     = 1'b0;
      lcg_state = 32'h5e5de137;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      base = total_errors();
      read_expect(uart_ctrl_addr, "prdata ctrl after reset",
                  ref_word(uart_ctrl_addr, 8'h00, 1'b0, 1'b0, 1'b0), '1);
      read_expect(uart_data_addr, "prdata data after reset",
                  ref_word(uart_data_addr, 8'h00, 1'b0, 1'b0, 1'b0), data_mask(1'b0));
      finish_test(1, "reset values", base);

      base = total_errors();
      ch = next_char();
      apb_write(uart_data_addr, {24'd0, ch}, waits, err);
      receive_char(ch, "prdata loopback data");
      read_expect(uart_data_addr, "prdata data after read",
                  ref_word(uart_data_addr, ch, 1'b0, 1'b0, 1'b0), data_mask(1'b0));
      finish_test(2, "loopback", base);

      // each write stalls until the frame before it is out, which is also received by then
      base = total_errors();
      prev = 8'h00;
      for (i = 0; i < n_chars; i++) begin
         ch = next_char();
         apb_write(uart_data_addr, {24'd0, ch}, waits, err);
         if (i > 0) begin
            if (waits == 0) begin
               $display("write %0d finished without wait states during a frame", i);
               misc_errors++;
            end
            receive_char(prev, "prdata burst data");
         end
         prev = ch;
      end
      receive_char(prev, "prdata burst data");
      finish_test(3, "back-to-back writes", base);

      base = total_errors();
      ch   = next_char();
      prev = next_char();
      apb_write(uart_data_addr, {24'd0, ch}, waits, err);
      apb_write(uart_data_addr, {24'd0, prev}, waits, err);
      wait_tx_idle();
      read_expect(uart_ctrl_addr, "prdata ctrl overrun set",
                  ref_word(uart_ctrl_addr, 8'h00, 1'b0, 1'b1, 1'b0), '1);
      read_expect(uart_data_addr, "prdata data after overrun",
                  ref_word(uart_data_addr, prev, 1'b1, 1'b0, 1'b0), '1);
      apb_write(uart_ctrl_addr, 32'd1 << overrun_bit, waits, err);
      read_expect(uart_ctrl_addr, "prdata ctrl overrun cleared",
                  ref_word(uart_ctrl_addr, 8'h00, 1'b0, 1'b0, 1'b0), '1);
      finish_test(4, "overrun", base);

      base = total_errors();
      ch = next_char();
      bang_frame(ch, 1'b0);
      read_expect(uart_data_addr, "prdata data after bad stop bit",
                  ref_word(uart_data_addr, ch, 1'b0, 1'b0, 1'b0), data_mask(1'b0));
      ch = next_char();
      bang_frame(ch, 1'b1);
      receive_char(ch, "prdata bit-banged data");
      finish_test(5, "framing", base);

      // leave a character waiting so that a stray effect would show
      base = total_errors();
      ch = next_char();
      apb_write(uart_data_addr, {24'd0, ch}, waits, err);
      wait_tx_idle();
      apb_write(bad_addr, 32'hffff_ffff, waits, err);
      expect_word("pslverr unmapped write", {31'd0, err}, 32'd1, '1);
      apb_read(bad_addr, word, err);
      expect_word("pslverr unmapped read", {31'd0, err}, 32'd1, '1);
      read_expect(uart_ctrl_addr, "prdata ctrl after unmapped access",
                  ref_word(uart_ctrl_addr, 8'h00, 1'b0, 1'b0, 1'b0), '1);
      read_expect(uart_data_addr, "prdata data after unmapped access",
                  ref_word(uart_data_addr, ch, 1'b1, 1'b0, 1'b0), '1);
      finish_test(6, "unmapped offset", base);

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               n_tests, failed_tests, checked, total_errors());
      if (total_errors() == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
